// ==== design/jpeg_store_pkg.sv ====
package jpeg_store_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] frame_count_t;
    typedef logic [7:0]  burst_len_t;     // words in the burst minus one.
    typedef logic [9:0]  fifo_level_t;
    typedef logic [3:0]  size_level_t;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT,
        CAP_ENCODE
    } capture_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_HEADER,
        RD_DATA,
        RD_FRAME_OVER
    } read_state_t;

    localparam int FIFO_DEPTH        = 512;
    localparam int ALMOST_FULL_LEVEL = 480;
    localparam int BURST_WORDS       = 256;
    localparam int SIZE_DEPTH        = 8;

endpackage

// ==== design/capture_frame_ctrl.sv ====
module capture_frame_ctrl import jpeg_store_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         capture_on,
    input  frame_count_t add_need_frame_num,
    input  logic         add_need_frame_pos,
    input  logic         frame_done,
    output frame_count_t total_need_frame_num,
    output logic         frame_start
);

    capture_state_t state;
    capture_state_t state_nxt;
    logic           done_hit;
    frame_count_t   add_term;

    assign done_hit = frame_done && (state == CAP_ENCODE); // a frame has fully left the store.
    assign add_term = add_need_frame_pos ? add_need_frame_num : '0;

    // the pulse lasts one cycle since the state moves on at the next edge.
    assign frame_start = capture_on && (state == CAP_WAIT) && (total_need_frame_num != '0);

    always_comb begin
        state_nxt = state;
        if (!capture_on) begin
            state_nxt = CAP_IDLE;
        end else begin
            case (state)
                CAP_IDLE:   state_nxt = CAP_WAIT;
                CAP_WAIT:   state_nxt = frame_start ? CAP_ENCODE : CAP_WAIT;
                CAP_ENCODE: state_nxt = done_hit ? CAP_WAIT : CAP_ENCODE;
                default:    state_nxt = CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= CAP_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            total_need_frame_num <= '0;
        end else if (!capture_on) begin
            total_need_frame_num <= '0;
        end else begin
            // an add and a finished frame in one cycle net out here.
            total_need_frame_num <= total_need_frame_num + add_term
                                    - frame_count_t'(done_hit);
        end
    end

endmodule

// ==== design/bitstream_fifo.sv ====
module bitstream_fifo import jpeg_store_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        capture_on,
    input  logic        wr_en,
    input  word_t       wr_word,
    input  logic        rd_take,
    output word_t       rd_word,
    output logic        word_ready,
    output fifo_level_t level,
    output logic        almost_full
);

    word_t                           mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    fifo_level_t                     mem_count;
    logic                            wr_fire;
    logic                            load;

    assign wr_fire = wr_en && (mem_count < fifo_level_t'(FIFO_DEPTH));
    // refill the output register when it is empty or being taken.
    assign load    = (mem_count != '0) && (!word_ready || rd_take);

    assign level       = mem_count + fifo_level_t'(word_ready);
    assign almost_full = (level >= fifo_level_t'(ALMOST_FULL_LEVEL));

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rd_word <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            mem_count  <= '0;
            word_ready <= 1'b0;
        end else if (!capture_on) begin
            wr_ptr     <= '0; // the stored stream is dropped when capture stops.
            rd_ptr     <= '0;
            mem_count  <= '0;
            word_ready <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            mem_count <= mem_count + fifo_level_t'(wr_fire) - fifo_level_t'(load);
            if (load) begin
                word_ready <= 1'b1;
            end else if (rd_take) begin
                word_ready <= 1'b0;
            end
        end
    end

endmodule

// ==== design/frame_size_fifo.sv ====
module frame_size_fifo import jpeg_store_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         capture_on,
    input  logic         enc_word_valid,
    input  logic         enc_frame_end,
    input  logic         frame_done,
    input  logic         rd_info_valid,
    output frame_count_t frame_words,
    output logic         frame_ended,
    output frame_count_t rd_info,
    output logic         rd_info_ready,
    output size_level_t  frame_save_num
);

    frame_count_t                  size_mem [SIZE_DEPTH];
    logic [$clog2(SIZE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(SIZE_DEPTH)-1:0] rd_ptr;
    size_level_t                   q_count;
    frame_count_t                  word_cnt;
    logic                          push_d;
    logic                          push;
    logic                          load;

    assign push = push_d && (q_count < size_level_t'(SIZE_DEPTH));
    assign load = (q_count != '0) && (!rd_info_ready || rd_info_valid);

    assign frame_save_num = q_count + size_level_t'(rd_info_ready);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_cnt    <= '0;
            frame_words <= '0;
            frame_ended <= 1'b0;
            push_d      <= 1'b0;
        end else if (!capture_on) begin
            word_cnt    <= '0;
            frame_words <= '0;
            frame_ended <= 1'b0;
            push_d      <= 1'b0;
        end else begin
            push_d <= enc_word_valid && enc_frame_end; // size enters the queue a cycle later.
            if (enc_word_valid && enc_frame_end) begin
                word_cnt    <= '0;
                frame_words <= word_cnt + 1'b1;
                frame_ended <= 1'b1;
            end else begin
                if (enc_word_valid) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (frame_done) begin
                    frame_words <= '0; // zero keeps a stale size from matching the next frame.
                    frame_ended <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            size_mem[wr_ptr] <= frame_words;
        end
        if (load) begin
            rd_info <= size_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_count       <= '0;
            rd_info_ready <= 1'b0;
        end else if (!capture_on) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_count       <= '0;
            rd_info_ready <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr + push;
            rd_ptr  <= rd_ptr + load;
            q_count <= q_count + size_level_t'(push) - size_level_t'(load);
            if (load) begin
                rd_info_ready <= 1'b1;
            end else if (rd_info_valid) begin
                rd_info_ready <= 1'b0; // the head was consumed with nothing behind it.
            end
        end
    end

endmodule

// ==== design/burst_word_counter.sv ====
module burst_word_counter import jpeg_store_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         capture_on,
    input  logic         burst_load,
    input  burst_len_t   load_len,
    input  logic         data_fire,
    input  frame_count_t frame_words,
    input  logic         frame_done,
    output logic         burst_last,
    output logic         frame_complete
);

    burst_len_t   words_left; // words still to send in this burst, minus one.
    frame_count_t words_sent;

    assign burst_last     = (words_left == '0);
    assign frame_complete = ((words_sent + 1'b1) == frame_words);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            words_left <= '0;
        end else if (!capture_on) begin
            words_left <= '0;
        end else if (burst_load) begin
            words_left <= load_len;
        end else if (data_fire && !burst_last) begin
            words_left <= words_left - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            words_sent <= '0;
        end else if (!capture_on || frame_done) begin
            words_sent <= '0;
        end else if (data_fire) begin
            words_sent <= words_sent + 1'b1;
        end
    end

endmodule

// ==== design/burst_read_ctrl.sv ====
module burst_read_ctrl import jpeg_store_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         capture_on,
    input  fifo_level_t  level,
    input  logic         word_ready,
    input  logic         frame_ended,
    input  frame_count_t frame_words,
    input  logic         burst_last,
    input  logic         frame_complete,
    input  logic         rd_data_burst_ready,
    input  logic         rd_data_ready,
    output logic         rd_data_burst_valid,
    output burst_len_t   rd_data_burst,
    output logic         burst_load,
    output burst_len_t   load_len,
    output logic         rd_data_valid,
    output logic         rd_data_last,
    output logic         rd_take,
    output logic         frame_done
);

    read_state_t  state;
    read_state_t  state_nxt;
    frame_count_t loaded;
    frame_count_t remaining;
    logic         full_burst;
    logic         tail_burst;

    assign remaining  = frame_words - loaded; // words of the frame not yet given a header.
    assign full_burst = (level >= fifo_level_t'(BURST_WORDS));
    assign tail_burst = frame_ended && (remaining != '0);

    assign burst_load = (state == RD_IDLE) && capture_on && (full_burst || tail_burst);
    assign load_len   = full_burst ? burst_len_t'(BURST_WORDS - 1)
                                   : burst_len_t'(remaining - 1'b1);

    assign rd_data_burst_valid = (state == RD_HEADER);
    assign rd_data_valid       = (state == RD_DATA) && word_ready;
    assign rd_data_last        = (state == RD_DATA) && burst_last;
    assign rd_take             = rd_data_valid && rd_data_ready;
    assign frame_done          = (state == RD_FRAME_OVER);

    always_comb begin
        state_nxt = state;
        if (!capture_on) begin
            state_nxt = RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (burst_load) begin
                        state_nxt = RD_HEADER;
                    end
                end
                RD_HEADER: begin
                    if (rd_data_burst_ready) begin
                        state_nxt = RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rd_take && burst_last) begin
                        state_nxt = frame_complete ? RD_FRAME_OVER : RD_IDLE;
                    end
                end
                default: state_nxt = RD_IDLE; // frame over lasts a single cycle.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state         <= RD_IDLE;
            loaded        <= '0;
            rd_data_burst <= '0;
        end else begin
            state <= state_nxt;
            if (!capture_on || frame_done) begin
                loaded <= '0;
            end else if (burst_load) begin
                loaded <= loaded + frame_count_t'(load_len) + 1'b1;
            end
            if (burst_load) begin
                rd_data_burst <= load_len;
            end
        end
    end

endmodule

// ==== design/jpeg_store_top.sv ====
module jpeg_store_top import jpeg_store_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         capture_on,
    input  frame_count_t add_need_frame_num,
    input  logic         add_need_frame_pos,
    input  logic         enc_word_valid,
    input  word_t        enc_word,
    input  logic         enc_frame_end,
    input  logic         rd_data_burst_ready,
    input  logic         rd_data_ready,
    input  logic         rd_info_valid,
    output frame_count_t total_need_frame_num,
    output logic         frame_start,
    output logic         enc_almost_full,
    output logic         rd_data_burst_valid,
    output burst_len_t   rd_data_burst,
    output logic         rd_data_valid,
    output word_t        rd_data,
    output logic         rd_data_last,
    output logic         rd_info_ready,
    output frame_count_t rd_info,
    output size_level_t  frame_save_num
);

    logic         frame_done;
    logic         frame_ended;
    frame_count_t frame_words;
    fifo_level_t  level;
    logic         word_ready;
    logic         rd_take;
    logic         burst_load;
    burst_len_t   load_len;
    logic         burst_last;
    logic         frame_complete;

    capture_frame_ctrl u_capture_frame_ctrl (
        .clk                  (clk),
        .rstn                 (rstn),
        .capture_on           (capture_on),
        .add_need_frame_num   (add_need_frame_num),
        .add_need_frame_pos   (add_need_frame_pos),
        .frame_done           (frame_done),
        .total_need_frame_num (total_need_frame_num),
        .frame_start          (frame_start)
    );

    bitstream_fifo u_bitstream_fifo (
        .clk         (clk),
        .rstn        (rstn),
        .capture_on  (capture_on),
        .wr_en       (enc_word_valid),
        .wr_word     (enc_word),
        .rd_take     (rd_take),
        .rd_word     (rd_data),
        .word_ready  (word_ready),
        .level       (level),
        .almost_full (enc_almost_full)
    );

    frame_size_fifo u_frame_size_fifo (
        .clk            (clk),
        .rstn           (rstn),
        .capture_on     (capture_on),
        .enc_word_valid (enc_word_valid),
        .enc_frame_end  (enc_frame_end),
        .frame_done     (frame_done),
        .rd_info_valid  (rd_info_valid),
        .frame_words    (frame_words),
        .frame_ended    (frame_ended),
        .rd_info        (rd_info),
        .rd_info_ready  (rd_info_ready),
        .frame_save_num (frame_save_num)
    );

    burst_word_counter u_burst_word_counter (
        .clk            (clk),
        .rstn           (rstn),
        .capture_on     (capture_on),
        .burst_load     (burst_load),
        .load_len       (load_len),
        .data_fire      (rd_take),
        .frame_words    (frame_words),
        .frame_done     (frame_done),
        .burst_last     (burst_last),
        .frame_complete (frame_complete)
    );

    burst_read_ctrl u_burst_read_ctrl (
        .clk                 (clk),
        .rstn                (rstn),
        .capture_on          (capture_on),
        .level               (level),
        .word_ready          (word_ready),
        .frame_ended         (frame_ended),
        .frame_words         (frame_words),
        .burst_last          (burst_last),
        .frame_complete      (frame_complete),
        .rd_data_burst_ready (rd_data_burst_ready),
        .rd_data_ready       (rd_data_ready),
        .rd_data_burst_valid (rd_data_burst_valid),
        .rd_data_burst       (rd_data_burst),
        .burst_load          (burst_load),
        .load_len            (load_len),
        .rd_data_valid       (rd_data_valid),
        .rd_data_last        (rd_data_last),
        .rd_take             (rd_take),
        .frame_done          (frame_done)
    );

endmodule

// ==== tb/jpeg_store_properties.sv ====
module jpeg_store_properties import jpeg_store_pkg::*; (
    input logic        clk,
    input logic        rstn,
    input logic        capture_on,
    input logic        rd_data_burst_valid,
    input logic        rd_data_burst_ready,
    input burst_len_t  rd_data_burst,
    input logic        rd_data_valid,
    input logic        rd_data_ready,
    input word_t       rd_data,
    input logic        rd_data_last,
    input logic        frame_start,
    input logic        frame_done,
    input logic        enc_almost_full,
    input fifo_level_t level
);

    int fail_count = 0; // read by the testbench at the end of the run.

    header_hold: assert property (@(posedge clk) disable iff (!rstn || !capture_on)
        rd_data_burst_valid && !rd_data_burst_ready |=>
            rd_data_burst_valid && $stable(rd_data_burst))
        else begin
            fail_count++;
            $error("burst header dropped or changed before ready");
        end

    data_hold: assert property (@(posedge clk) disable iff (!rstn || !capture_on)
        rd_data_valid && !rd_data_ready |=>
            rd_data_valid && $stable(rd_data) && $stable(rd_data_last))
        else begin
            fail_count++;
            $error("data word dropped or changed before ready");
        end

    start_pulse: assert property (@(posedge clk) disable iff (!rstn)
        frame_start |=> !frame_start)
        else begin
            fail_count++;
            $error("frame_start longer than one cycle");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        frame_done |=> !frame_done)
        else begin
            fail_count++;
            $error("frame_done longer than one cycle");
        end

    level_bound: assert property (@(posedge clk) disable iff (!rstn)
        !(enc_almost_full && (level > fifo_level_t'(FIFO_DEPTH))))
        else begin
            fail_count++;
            $error("fifo level above its depth");
        end

endmodule

// ==== tb/jpeg_store_tb.sv ====
module jpeg_store_tb import jpeg_store_pkg::*; ();

    localparam int STEP_LIMIT = 200000;

    logic         clk, rstn, capture_on;
    logic         add_need_frame_pos, enc_word_valid, enc_frame_end;
    logic         rd_data_burst_ready, rd_data_ready, rd_info_valid;
    logic         frame_start, enc_almost_full, rd_data_burst_valid;
    logic         rd_data_valid, rd_data_last, rd_info_ready;
    frame_count_t add_need_frame_num, total_need_frame_num, rd_info;
    word_t        enc_word, rd_data;
    burst_len_t   rd_data_burst;
    size_level_t  frame_save_num;

    logic [31:0]  rng = 32'd16171;
    word_t        word_q[$];   // words written and not yet read out.
    frame_count_t size_q[$];   // finished sizes not yet taken through rd_info.
    frame_count_t rx_sizes[$]; // sizes of frames still leaving as bursts.
    frame_count_t force_q[$];
    burst_len_t   hdr_q[$];
    frame_count_t model_need, add_pend, enc_left, enc_size, rx_count;
    int           model_saved, burst_cnt, burst_code, adds_left, ready_level;
    int           starts_seen = 0;
    int           tests = 0;
    int           checks = 0;
    int           errors = 0;
    logic         done_p1, done_p2, end_p1, end_p2, info_pend;
    logic         timed_out = 1'b0;

    jpeg_store_top dut0 (.*);

    bind jpeg_store_top jpeg_store_properties props0 (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("%s at time %0t", msg, $time);
    endtask

    task automatic clear_model();
        word_q.delete();
        size_q.delete();
        rx_sizes.delete();
        hdr_q.delete();
        model_need = '0;
        add_pend = '0;
        enc_left = '0;
        enc_size = '0;
        rx_count = '0;
        model_saved = 0;
        burst_cnt = 0;
        burst_code = 0;
        adds_left = 0;
        {done_p1, done_p2, end_p1, end_p2, info_pend} = '0;
    endtask

    function automatic logic store_drained();
        return adds_left == 0 && add_pend == 0 && model_need == 0 && !info_pend
               && size_q.size() == 0 && model_saved == 0;
    endfunction

    // one clock of encoder, reader and consumer, all driven on the falling edge.
    task automatic step();
        logic         hdr_rdy;
        logic         dat_rdy;
        logic         info_req;
        frame_count_t n;
        int           k;
        @(negedge clk);
        model_need = model_need + add_pend - frame_count_t'(done_p2); // count lags by a cycle.
        model_saved = model_saved + int'(end_p2) - int'(info_pend);
        add_pend = '0;
        done_p2 = done_p1;
        end_p2 = end_p1;
        {done_p1, end_p1, info_pend} = '0;
        check_eq("total_need_frame_num", total_need_frame_num, model_need);
        check_eq("frame_save_num", frame_save_num, model_saved);
        // the stored words are those written and not yet read out.
        check_eq("enc_almost_full", enc_almost_full, word_q.size() >= ALMOST_FULL_LEVEL);
        if (frame_start) begin
            starts_seen++;
            if (force_q.size() != 0) begin
                n = force_q.pop_front();
            end else begin
                n = 1 + xorshift() % 700;
            end
            enc_left = n;
            enc_size = n;
            rx_sizes.push_back(n);
            for (k = 0; k < n / BURST_WORDS; k++) begin
                hdr_q.push_back(burst_len_t'(BURST_WORDS - 1));
            end
            if (n % BURST_WORDS != 0) begin
                hdr_q.push_back(burst_len_t'(n % BURST_WORDS - 1)); // the tail burst.
            end
        end
        hdr_rdy = (xorshift() % 8) < ready_level;
        if (rd_data_burst_valid && hdr_rdy) begin
            assert (hdr_q.size() != 0) else note_error("burst header with none expected");
            if (hdr_q.size() != 0) begin
                burst_code = hdr_q.pop_front();
                check_eq("burst code", rd_data_burst, burst_code);
            end
            burst_cnt = 0;
        end
        dat_rdy = (xorshift() % 8) < ready_level;
        if (rd_data_valid && dat_rdy) begin
            assert (word_q.size() != 0) else note_error("data word with none expected");
            if (word_q.size() != 0) begin
                check_eq("data word", rd_data, word_q.pop_front());
            end
            check_eq("rd_data_last", rd_data_last, burst_cnt == burst_code);
            burst_cnt++;
            rx_count++;
            if (rx_sizes.size() != 0 && rx_count == rx_sizes[0]) begin
                void'(rx_sizes.pop_front());
                rx_count = '0;
                done_p1 = 1'b1;
            end
        end
        info_req = rd_info_ready && (xorshift() % 4 == 0);
        if (info_req) begin
            assert (size_q.size() != 0) else note_error("frame size offered with none expected");
            if (size_q.size() != 0) begin
                check_eq("rd_info", rd_info, size_q.pop_front());
            end
            info_pend = 1'b1;
        end
        enc_word_valid = 1'b0;
        enc_frame_end = 1'b0;
        if (enc_left != 0 && !enc_almost_full && (xorshift() % 4 != 0)) begin
            enc_word_valid = 1'b1;
            enc_word = xorshift();
            enc_frame_end = (enc_left == 1);
            word_q.push_back(enc_word);
            enc_left--;
            if (enc_frame_end) begin
                size_q.push_back(enc_size);
                end_p1 = 1'b1;
            end
        end
        add_need_frame_num = xorshift() % 16; // ignored unless the strobe is high.
        add_need_frame_pos = 1'b0;
        if (adds_left > 0 && (xorshift() % 32 == 0)) begin
            add_pend = 1 + xorshift() % ((adds_left < 3) ? adds_left : 3);
            adds_left = adds_left - int'(add_pend);
            add_need_frame_num = add_pend;
            add_need_frame_pos = 1'b1;
        end
        rd_data_burst_ready = hdr_rdy;
        rd_data_ready = dat_rdy;
        rd_info_valid = info_req;
    endtask

    task automatic run_frames(input string name, input int frames, input int rdy);
        int steps;
        int err0;
        int starts0;
        err0 = errors;
        starts0 = starts_seen;
        adds_left = frames;
        ready_level = rdy;
        steps = 0;
        do begin
            step();
            steps++;
        end while (!store_drained() && steps < STEP_LIMIT);
        if (!store_drained()) begin
            timed_out = 1'b1;
            note_error($sformatf("timeout waiting for test %s to drain", name));
        end
        check_eq("frame_start pulses", starts_seen - starts0, frames);
        tests++;
        $display("test %s: %0d frames, %0d cycles, %0d errors", name, frames, steps,
                 errors - err0);
    endtask

    task automatic drop_capture();
        int err0;
        err0 = errors;
        adds_left = 3;
        ready_level = 5;
        repeat (600) step();
        @(negedge clk);
        capture_on = 1'b0;
        enc_word_valid = 1'b0;
        add_need_frame_pos = 1'b0;
        rd_data_burst_ready = 1'b0;
        rd_data_ready = 1'b0;
        rd_info_valid = 1'b0;
        @(negedge clk);
        check_eq("count after capture off", total_need_frame_num, '0);
        check_eq("valids after capture off",
                 {frame_start, rd_data_burst_valid, rd_data_valid, rd_info_ready}, '0);
        check_eq("frame_save_num after capture off", frame_save_num, '0);
        clear_model();
        capture_on = 1'b1;
        tests++;
        $display("test capture_drop: %0d errors", errors - err0);
    endtask

    task automatic finish_run();
        errors = errors + dut0.props0.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        capture_on = 1'b0;
        add_need_frame_num = '0;
        add_need_frame_pos = 1'b0;
        enc_word_valid = 1'b0;
        enc_word = '0;
        enc_frame_end = 1'b0;
        rd_data_burst_ready = 1'b0;
        rd_data_ready = 1'b0;
        rd_info_valid = 1'b0;
        clear_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_eq("outputs after reset", {rd_data_burst_valid, rd_data_valid, rd_info_ready,
                 frame_start, enc_almost_full}, '0);
        check_eq("count after reset", total_need_frame_num, '0);
        tests++;
        $display("test reset_values: %0d errors", errors);
        capture_on = 1'b1;
        force_q = '{256, 512}; // exact multiples of the burst size come first.
        run_frames("fast_reader", 4, 8);
        if (!timed_out) begin
            run_frames("back_pressure", 8, 3);
        end
        if (!timed_out) begin
            drop_capture();
        end
        if (!timed_out) begin
            run_frames("after_restart", 2, 6);
        end
        finish_run();
    end

endmodule

// ==== jpeg_store.f ====
design/jpeg_store_pkg.sv
design/capture_frame_ctrl.sv
design/bitstream_fifo.sv
design/frame_size_fifo.sv
design/burst_word_counter.sv
design/burst_read_ctrl.sv
design/jpeg_store_top.sv
tb/jpeg_store_properties.sv
tb/jpeg_store_tb.sv
